//--- common/robot_pkg.sv
package robot_pkg;

    typedef logic [7:0] key_code_t;     // Remote key code
    typedef logic [2:0] cam_dir_t;      // Camera direction
    typedef logic [1:0] speed_t;        // Speed class 0 to 2
    typedef logic [6:0] seg_t;          // Active low, bit 0 is segment a

    typedef enum logic [1:0] {
        mode_idle = 2'd0,
        mode_cam  = 2'd1,
        mode_ir   = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        cam_search = 2'd0,
        cam_follow = 2'd1,
        cam_pause  = 2'd3               // Code 2 unused
    } cam_state_t;

    typedef enum logic [2:0] {
        drv_stop   = 3'd0,
        drv_left   = 3'd1,
        drv_right  = 3'd2,
        drv_slow   = 3'd3,
        drv_medium = 3'd4,
        drv_fast   = 3'd5
    } drive_t;

    localparam cam_dir_t dir_left  = 3'd1;
    localparam cam_dir_t dir_right = 3'd2;
    localparam cam_dir_t dir_ahead = 3'd3;

    // Remote keys
    localparam key_code_t key_cam    = 8'h0F;
    localparam key_code_t key_ir     = 8'h13;
    localparam key_code_t key_idle   = 8'h10;
    localparam key_code_t key_stop   = 8'h0C;
    localparam key_code_t key_left   = 8'h14;
    localparam key_code_t key_right  = 8'h18;
    localparam key_code_t key_fast   = 8'h1B;
    localparam key_code_t key_medium = 8'h19;
    localparam key_code_t key_slow   = 8'h1A;

    typedef struct packed {
        logic     detected;             // Object in view
        cam_dir_t direction;
        speed_t   speed;
    } cam_in_t;

    typedef struct packed {
        mode_t      mode;
        cam_state_t cam_state;
        drive_t     drive;
    } fsm_status_t;

    typedef struct packed {
        logic left_en;
        logic left_fwd;
        logic right_en;
        logic right_fwd;
    } motor_t;

endpackage

//--- ir/ir_key_rx.sv
`timescale 1ns/10ps

module ir_key_rx (
    input  logic                 clk_50,
    input  logic                 rst,
    input  logic                 key_req,
    input  robot_pkg::key_code_t key_code,
    output logic                 key_ack,
    output logic                 key_strobe,
    output robot_pkg::key_code_t key
);

    import robot_pkg::*;

    typedef enum logic [1:0] {
        wait_req     = 2'd0,
        ack_high     = 2'd1,            // First ack cycle, strobe out
        wait_release = 2'd2
    } rx_state_t;

    rx_state_t state;

    always_ff @(posedge clk_50) begin
        if (rst) begin
            state <= wait_req;
        end else begin
            case (state)
                wait_req: begin
                    if (key_req) begin
                        state <= ack_high;
                    end
                end
                ack_high: begin
                    state <= key_req ? wait_release : wait_req;
                end
                wait_release: begin
                    if (!key_req) begin
                        state <= wait_req; // Return to zero done
                    end
                end
                default: begin
                    state <= wait_req;
                end
            endcase
        end
    end

    // Code is stable while req is high
    always_ff @(posedge clk_50) begin
        if (state == wait_req && key_req) begin
            key <= key_code;
        end
    end

    assign key_ack    = (state != wait_req);
    assign key_strobe = (state == ack_high); // Once per transaction

    // Ack only answers a request seen at the previous edge
    a_ack_after_req: assert property (
        @(posedge clk_50) disable iff (rst)
        $rose(key_ack) |-> $past(key_req)
    );

endmodule

//--- mode_fsm/mode_fsm.sv
`timescale 1ns/10ps

module mode_fsm (
    input  logic                   clk_50,
    input  logic                   rst,
    input  logic                   key_strobe,
    input  robot_pkg::key_code_t   key,
    input  robot_pkg::cam_in_t     cam,
    output robot_pkg::fsm_status_t status,
    output logic                   mode_change
);

    import robot_pkg::*;

    mode_t      next_mode;
    cam_state_t next_cam;
    drive_t     next_drive;
    drive_t     cam_drive;              // Command from camera rules
    drive_t     key_drive;              // Command from a drive key
    logic       key_is_drive;

    always_comb begin
        next_mode = status.mode;
        if (key_strobe) begin
            case (key)
                key_cam:  next_mode = mode_cam;
                key_ir:   next_mode = mode_ir;
                key_idle: next_mode = mode_idle;
                default:  next_mode = status.mode;
            endcase
        end
    end

    always_comb begin
        if (next_mode != mode_cam) begin
            next_cam = cam_pause;
        end else begin
            case (status.cam_state)
                cam_search: next_cam = cam.detected ? cam_follow : cam_search;
                cam_follow: next_cam = cam.detected ? cam_follow : cam_search;
                default:    next_cam = cam_search; // Entering cam from pause
            endcase
        end
    end

    // Uses the camera sub-state being entered
    always_comb begin
        cam_drive = drv_stop;
        if (next_cam == cam_search) begin
            cam_drive = drv_right;      // Turn on the spot while looking
        end else if (next_cam == cam_follow) begin
            case (cam.direction)
                dir_left:  cam_drive = drv_left;
                dir_right: cam_drive = drv_right;
                dir_ahead: begin
                    case (cam.speed)
                        2'd0:    cam_drive = drv_slow;
                        2'd1:    cam_drive = drv_medium;
                        2'd2:    cam_drive = drv_fast;
                        default: cam_drive = drv_stop;
                    endcase
                end
                default: cam_drive = drv_stop;
            endcase
        end
    end

    always_comb begin
        key_is_drive = 1'b1;
        case (key)
            key_stop:   key_drive = drv_stop;
            key_left:   key_drive = drv_left;
            key_right:  key_drive = drv_right;
            key_slow:   key_drive = drv_slow;
            key_medium: key_drive = drv_medium;
            key_fast:   key_drive = drv_fast;
            default: begin
                key_drive    = drv_stop;
                key_is_drive = 1'b0;    // Not a drive key
            end
        endcase
    end

    always_comb begin
        case (next_mode)
            mode_cam: begin
                next_drive = cam_drive;
            end
            mode_ir: begin
                if (status.mode != mode_ir) begin
                    next_drive = drv_stop; // Fresh entry into remote drive
                end else if (key_strobe && key_is_drive) begin
                    next_drive = key_drive;
                end else begin
                    next_drive = status.drive;
                end
            end
            default: begin
                next_drive = drv_stop;
            end
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (rst) begin
            status.mode      <= mode_idle;
            status.cam_state <= cam_pause;
            status.drive     <= drv_stop;
            mode_change      <= 1'b0;
        end else begin
            status.mode      <= next_mode;
            status.cam_state <= next_cam;
            status.drive     <= next_drive;
            mode_change      <= (next_mode != status.mode) ||
                                (next_cam != status.cam_state);
        end
    end

    a_idle_stop: assert property (
        @(posedge clk_50) disable iff (rst)
        status.mode == mode_idle |-> status.drive == drv_stop
    );

endmodule

//--- src/motor_pwm.sv
`timescale 1ns/10ps

module motor_pwm #(
    parameter int pwm_period = 16
) (
    input  logic                   clk_50,
    input  logic                   rst,
    input  robot_pkg::fsm_status_t status,
    output robot_pkg::motor_t      motor
);

    import robot_pkg::*;

    localparam int cnt_w = $clog2(pwm_period);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(pwm_period - 1);
    localparam logic [cnt_w:0] quarter_time = (cnt_w + 1)'(pwm_period / 4);
    localparam logic [cnt_w:0] half_time    = (cnt_w + 1)'(pwm_period / 2);
    localparam logic [cnt_w:0] three_q_time = (cnt_w + 1)'((3 * pwm_period) / 4);

    logic [cnt_w-1:0] cnt;              // Free running period counter
    logic [cnt_w:0]   high_time;
    logic             left_fwd;
    logic             right_fwd;
    logic             pwm_on;

    always_comb begin
        left_fwd  = 1'b1;
        right_fwd = 1'b1;
        case (status.drive)
            drv_slow:   high_time = quarter_time;
            drv_medium: high_time = half_time;
            drv_fast:   high_time = three_q_time;
            drv_left: begin
                high_time = half_time;
                left_fwd  = 1'b0;       // Spin left in place
            end
            drv_right: begin
                high_time = half_time;
                right_fwd = 1'b0;
            end
            default: high_time = '0;    // Stop
        endcase
    end

    assign pwm_on = ({1'b0, cnt} < high_time);

    always_ff @(posedge clk_50) begin
        if (rst) begin
            cnt   <= '0;
            motor <= '0;
        end else begin
            cnt             <= (cnt == cnt_max) ? '0 : cnt + 1'b1;
            motor.left_en   <= pwm_on;
            motor.left_fwd  <= left_fwd;
            motor.right_en  <= pwm_on;
            motor.right_fwd <= right_fwd;
        end
    end

    a_stop_quiet: assert property (
        @(posedge clk_50) disable iff (rst)
        $past(status.drive) == drv_stop |-> !motor.left_en && !motor.right_en
    );

endmodule

//--- display/status_display.sv
`timescale 1ns/10ps

module status_display (
    input  robot_pkg::fsm_status_t status,
    output robot_pkg::seg_t        hex0,
    output robot_pkg::seg_t        hex1,
    output robot_pkg::seg_t        hex2,
    output robot_pkg::seg_t        hex3,
    output robot_pkg::seg_t        hex4,
    output robot_pkg::seg_t        hex5,
    output robot_pkg::seg_t        hex6,
    output robot_pkg::seg_t        hex7
);

    import robot_pkg::*;

    // Patterns written as g..a, low lights a segment
    localparam seg_t seg_blank = 7'b1111111;
    localparam seg_t seg_i     = 7'b1111001;
    localparam seg_t seg_d     = 7'b0100001;
    localparam seg_t seg_c     = 7'b1000110;
    localparam seg_t seg_a     = 7'b0001000;
    localparam seg_t seg_r     = 7'b0101111;
    localparam seg_t seg_s     = 7'b0010010; // Also digit 5
    localparam seg_t seg_f     = 7'b0001110;
    localparam seg_t seg_p     = 7'b0001100;
    localparam seg_t seg_t_low = 7'b0000111;
    localparam seg_t seg_o     = 7'b0100011; // Lower case o
    localparam seg_t seg_l     = 7'b1000111;
    localparam seg_t seg_e     = 7'b0000110;
    localparam seg_t seg_g     = 7'b1000010;
    localparam seg_t seg_h     = 7'b0001001;
    localparam seg_t seg_1     = 7'b1111001;
    localparam seg_t seg_2     = 7'b0100100;
    localparam seg_t seg_3     = 7'b0110000;

    always_comb begin
        case (status.mode)
            mode_idle: {hex7, hex6} = {seg_i, seg_d};
            mode_cam:  {hex7, hex6} = {seg_c, seg_a};
            mode_ir:   {hex7, hex6} = {seg_i, seg_r};
            default:   {hex7, hex6} = {seg_blank, seg_blank};
        endcase
    end

    assign hex5 = seg_blank;            // Gap between mode and sub-state

    always_comb begin
        case (status.cam_state)
            cam_search: hex4 = seg_s;
            cam_follow: hex4 = seg_f;
            cam_pause:  hex4 = seg_p;
            default:    hex4 = seg_blank;
        endcase
    end

    always_comb begin
        case (status.drive)
            drv_stop:   {hex3, hex2, hex1, hex0} = {seg_s, seg_t_low, seg_o, seg_p};
            drv_left:   {hex3, hex2, hex1, hex0} = {seg_l, seg_e, seg_f, seg_t_low};
            drv_right:  {hex3, hex2, hex1, hex0} = {seg_r, seg_g, seg_h, seg_t_low};
            drv_slow:   {hex3, hex2, hex1, hex0} = {seg_s, seg_p, seg_blank, seg_1};
            drv_medium: {hex3, hex2, hex1, hex0} = {seg_s, seg_p, seg_blank, seg_2};
            drv_fast:   {hex3, hex2, hex1, hex0} = {seg_s, seg_p, seg_blank, seg_3};
            default: begin
                {hex3, hex2, hex1, hex0} = {seg_blank, seg_blank, seg_blank, seg_blank};
            end
        endcase
    end

endmodule

//--- src/robot_ctrl_top.sv
`timescale 1ns/10ps

module robot_ctrl_top #(
    parameter int pwm_period = 16
) (
    input  logic                 clk_50,
    input  logic                 rst,
    input  logic                 key_req,
    input  robot_pkg::key_code_t key_code,
    output logic                 key_ack,
    input  robot_pkg::cam_in_t   cam,
    output logic                 mode_change,
    output robot_pkg::motor_t    motor,
    output robot_pkg::seg_t      hex0,
    output robot_pkg::seg_t      hex1,
    output robot_pkg::seg_t      hex2,
    output robot_pkg::seg_t      hex3,
    output robot_pkg::seg_t      hex4,
    output robot_pkg::seg_t      hex5,
    output robot_pkg::seg_t      hex6,
    output robot_pkg::seg_t      hex7
);

    import robot_pkg::*;

    logic        key_strobe;            // One cycle per remote key
    key_code_t   key;
    fsm_status_t status;

    ir_key_rx u_rx (
        .clk_50     (clk_50),
        .rst        (rst),
        .key_req    (key_req),
        .key_code   (key_code),
        .key_ack    (key_ack),
        .key_strobe (key_strobe),
        .key        (key)
    );

    mode_fsm u_fsm (
        .clk_50      (clk_50),
        .rst         (rst),
        .key_strobe  (key_strobe),
        .key         (key),
        .cam         (cam),
        .status      (status),
        .mode_change (mode_change)
    );

    motor_pwm #(
        .pwm_period (pwm_period)
    ) u_motor (
        .clk_50 (clk_50),
        .rst    (rst),
        .status (status),
        .motor  (motor)
    );

    status_display u_display (
        .status (status),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .hex4   (hex4),
        .hex5   (hex5),
        .hex6   (hex6),
        .hex7   (hex7)
    );

endmodule

//--- test/tb_robot_ctrl.sv
`timescale 1ns/10ps

module tb_robot_ctrl;

    import robot_pkg::*;

    localparam int pwm_period = 16;

    typedef struct packed {
        logic       has_key;
        key_code_t  key;
        cam_in_t    cam;
        int         hold;               // Extra cycles req stays high after ack
        mode_t      mode;
        cam_state_t cs;
        drive_t     drv;
        int         changes;            // Expected mode_change high cycles
    } step_t;

    logic       clk_50;
    logic       rst;
    logic       key_req;
    key_code_t  key_code;
    logic       key_ack;
    cam_in_t    cam;
    logic       mode_change;
    motor_t     motor;
    seg_t       hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    int         change_cnt = 0;
    integer     seed;
    logic [31:0] rnd;
    cam_state_t prev_cs;
    step_t      rnd_step;

    // Display text indexed by enum value
    string mode_txt [3] = '{"Id", "CA", "Ir"};
    string cam_txt [4] = '{"S", "F", "?", "P"};
    string drive_txt [6] = '{"StoP", "LEFt", "rGHt", "SP 1", "SP 2", "SP 3"};

    // Letter shapes, active low, written g..a
    string glyphs = "IdCArSFPtoLEGH123 ";
    seg_t glyph_segs [18] = '{
        7'b1111001, 7'b0100001, 7'b1000110, 7'b0001000, 7'b0101111, 7'b0010010,
        7'b0001110, 7'b0001100, 7'b0000111, 7'b0100011, 7'b1000111, 7'b0000110,
        7'b1000010, 7'b0001001, 7'b1111001, 7'b0100100, 7'b0110000, 7'b1111111
    };

    step_t steps [28] = '{
        '{1'b0, 8'h00, '{1'b0, 3'd0, 2'd0}, 0, mode_idle, cam_pause, drv_stop, 0},
        '{1'b1, key_idle, '{1'b0, 3'd0, 2'd0}, 0, mode_idle, cam_pause, drv_stop, 0},
        '{1'b1, key_fast, '{1'b0, 3'd0, 2'd0}, 0, mode_idle, cam_pause, drv_stop, 0},
        '{1'b1, key_cam, '{1'b0, 3'd0, 2'd0}, 0, mode_cam, cam_search, drv_right, 1},
        '{1'b0, 8'h00, '{1'b1, 3'd3, 2'd0}, 0, mode_cam, cam_follow, drv_slow, 1},
        '{1'b0, 8'h00, '{1'b1, 3'd3, 2'd1}, 0, mode_cam, cam_follow, drv_medium, 0},
        '{1'b0, 8'h00, '{1'b1, 3'd3, 2'd2}, 0, mode_cam, cam_follow, drv_fast, 0},
        '{1'b0, 8'h00, '{1'b1, 3'd1, 2'd0}, 0, mode_cam, cam_follow, drv_left, 0},
        '{1'b0, 8'h00, '{1'b1, 3'd2, 2'd0}, 0, mode_cam, cam_follow, drv_right, 0},
        '{1'b0, 8'h00, '{1'b1, 3'd3, 2'd3}, 0, mode_cam, cam_follow, drv_stop, 0},
        '{1'b0, 8'h00, '{1'b0, 3'd3, 2'd2}, 0, mode_cam, cam_search, drv_right, 1},
        '{1'b1, key_cam, '{1'b0, 3'd1, 2'd0}, 0, mode_cam, cam_search, drv_right, 0},
        '{1'b1, key_ir, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_stop, 1},
        '{1'b1, key_fast, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_fast, 0},
        '{1'b1, key_left, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_left, 0},
        '{1'b1, key_right, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_right, 0},
        '{1'b1, key_slow, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_slow, 0},
        '{1'b1, key_medium, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_medium, 0},
        '{1'b1, 8'h55, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_medium, 0},
        '{1'b1, key_ir, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_medium, 0},
        '{1'b1, key_stop, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_stop, 0},
        '{1'b1, key_cam, '{1'b1, 3'd1, 2'd0}, 0, mode_cam, cam_follow, drv_left, 2},
        '{1'b1, key_ir, '{1'b1, 3'd1, 2'd0}, 25, mode_ir, cam_pause, drv_stop, 1},
        '{1'b1, key_idle, '{1'b0, 3'd0, 2'd0}, 0, mode_idle, cam_pause, drv_stop, 1},
        '{1'b1, key_ir, '{1'b0, 3'd0, 2'd0}, 0, mode_ir, cam_pause, drv_stop, 1},
        '{1'b1, key_cam, '{1'b0, 3'd0, 2'd0}, 0, mode_cam, cam_search, drv_right, 1},
        '{1'b1, key_idle, '{1'b0, 3'd0, 2'd0}, 0, mode_idle, cam_pause, drv_stop, 1},
        '{1'b1, key_cam, '{1'b1, 3'd3, 2'd1}, 0, mode_cam, cam_follow, drv_medium, 2}
    };

    robot_ctrl_top #(.pwm_period(pwm_period)) u_dut (.*);

    initial begin
        clk_50 = 1'b0;
        forever #4 clk_50 = ~clk_50;
    end

    always @(posedge clk_50) begin
        if (mode_change === 1'b1) begin
            change_cnt <= change_cnt + 1; // Counts the cycle just ended
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic seg_t glyph_seg(input byte c);
        seg_t s;
        int i;
        s = 7'b1111111;
        for (i = 0; i < glyphs.len(); i++) begin
            if (glyphs[i] == c) s = glyph_segs[i];
        end
        return s;
    endfunction

    task automatic check_display(input mode_t m, input cam_state_t cs, input drive_t d);
        string txt;
        logic [55:0] exp_segs;
        int i;
        txt = {mode_txt[m], " ", cam_txt[cs], drive_txt[d]};
        exp_segs = '0;
        for (i = 0; i < 8; i++) begin
            exp_segs = {exp_segs[48:0], glyph_seg(txt[i])};
        end
        assert ({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0} === exp_segs)
        else stop_on_error($sformatf("error at time %0t: hex7..hex0 expected %h (%s) actual %h",
            $time, exp_segs, txt, {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0}));
    endtask

    task automatic check_motor(input drive_t d);
        int left_hi;
        int right_hi;
        int exp_hi;
        logic [1:0] exp_fwd;            // Left wheel, right wheel
        left_hi = 0;
        right_hi = 0;
        exp_hi = pwm_period / 2;
        case (d)
            drv_stop: exp_hi = 0;
            drv_slow: exp_hi = pwm_period / 4;
            drv_fast: exp_hi = 3 * pwm_period / 4;
            drv_left: exp_fwd = 2'b01;
            drv_right: exp_fwd = 2'b10;
            default: exp_fwd = 2'b11;
        endcase
        if (d inside {drv_slow, drv_fast}) exp_fwd = 2'b11;
        repeat (pwm_period) begin
            @(negedge clk_50);
            if (motor.left_en) left_hi++;
            if (motor.right_en) right_hi++;
            assert (d == drv_stop || {motor.left_fwd, motor.right_fwd} === exp_fwd)
            else stop_on_error($sformatf("error at time %0t: motor fwd expected %b actual %b",
                $time, exp_fwd, {motor.left_fwd, motor.right_fwd}));
        end
        assert (left_hi == exp_hi && right_hi == exp_hi)
        else stop_on_error($sformatf(
            "error at time %0t: motor enable high cycles expected %0d actual %0d and %0d",
            $time, exp_hi, left_hi, right_hi));
    endtask

    // Four-phase transfer of one key code
    task automatic send_key(input key_code_t code, input int hold);
        int n;
        key_code = code;
        key_req = 1'b1;
        n = 0;
        while (key_ack !== 1'b1) begin
            @(negedge clk_50);
            n++;
            assert (n < 20) else stop_on_error("key_ack never answered key_req");
        end
        repeat (hold) begin
            @(negedge clk_50);
            assert (key_ack === 1'b1)
            else stop_on_error($sformatf("error at time %0t: key_ack expected 1 actual %b",
                $time, key_ack));
        end
        key_req = 1'b0;
        n = 0;
        while (key_ack !== 1'b0) begin
            @(negedge clk_50);
            n++;
            assert (n < 20) else stop_on_error("key_ack stayed high after key_req dropped");
        end
    endtask

    // Settled sub-state and drive for steady cam inputs while in cam mode
    function automatic step_t cam_model(input cam_in_t c, input cam_state_t prev);
        step_t s;
        s = '{1'b0, 8'h00, c, 0, mode_cam, cam_search, drv_right, 0};
        if (c.detected) begin
            s.cs = cam_follow;
            case (c.direction)
                3'd1: s.drv = drv_left;
                3'd2: s.drv = drv_right;
                3'd3: s.drv = (c.speed == 2'd0) ? drv_slow :
                              (c.speed == 2'd1) ? drv_medium :
                              (c.speed == 2'd2) ? drv_fast : drv_stop;
                default: s.drv = drv_stop;
            endcase
        end
        s.changes = (s.cs != prev) ? 1 : 0;
        return s;
    endfunction

    task automatic run_step(input step_t s);
        int start_cnt;
        cam = s.cam;
        start_cnt = change_cnt;
        if (s.has_key) begin
            send_key(s.key, s.hold);
        end
        repeat (3) @(negedge clk_50);
        check_display(s.mode, s.cs, s.drv);
        assert (change_cnt - start_cnt == s.changes)
        else stop_on_error($sformatf(
            "error at time %0t: mode_change cycles expected %0d actual %0d",
            $time, s.changes, change_cnt - start_cnt));
        check_motor(s.drv);
    endtask

    initial begin
        seed = 32'ha2df_68c0;
        rst = 1'b1;
        key_req = 1'b0;
        key_code = '0;
        cam = '0;
        repeat (8) @(negedge clk_50);
        rst = 1'b0;
        assert (key_ack === 1'b0)
        else stop_on_error($sformatf("error at time %0t: key_ack expected 0 actual %b",
            $time, key_ack));
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        prev_cs = cam_follow;           // Table ends following in cam mode
        repeat (40) begin
            rnd = $random(seed);
            rnd_step = cam_model(cam_in_t'(rnd[5:0]), prev_cs);
            run_step(rnd_step);
            prev_cs = rnd_step.cs;
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- robot_ctrl_top.f
common/robot_pkg.sv
ir/ir_key_rx.sv
mode_fsm/mode_fsm.sv
src/motor_pwm.sv
display/status_display.sv
src/robot_ctrl_top.sv
test/tb_robot_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_robot_ctrl -f robot_ctrl_top.f -o sim_robot_ctrl

./obj_dir/sim_robot_ctrl
